//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= src.f
BUILD_DIR ?= build
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/fetch_pkg.sv
package fetch_pkg;

    // address and instruction width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] word_t;

    // memory side beat
    localparam int BEAT_BITS = 64;

    typedef logic [BEAT_BITS-1:0] beat_t;

    // cache line geometry
    localparam int LINE_BITS      = 256;
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;
    localparam int WORDS_PER_LINE = LINE_BITS / XLEN;
    localparam int OFFSET_BITS    = 5;  // byte offset in a line

    typedef logic [LINE_BITS-1:0] line_t;

endpackage

//--- logic/fetch_queue.sv
module fetch_queue #(
    parameter int QUEUE_DEPTH = 8,
    parameter int CREDITS     = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             enq_i,
    input  fetch_pkg::addr_t enq_pc_i,
    input  fetch_pkg::word_t enq_inst_i,
    input  logic             inflight_i,
    output logic             full_o,

    output logic             fetch_valid_o,
    output fetch_pkg::addr_t fetch_pc_o,
    output fetch_pkg::word_t fetch_inst_o,
    input  logic             credit_return_i
);

    localparam int PTR_BITS  = $clog2(QUEUE_DEPTH);
    localparam int CNT_BITS  = $clog2(QUEUE_DEPTH + 1);
    localparam int CRED_BITS = $clog2(CREDITS + 1);

    fetch_pkg::addr_t pc_mem   [QUEUE_DEPTH];
    fetch_pkg::word_t inst_mem [QUEUE_DEPTH];

    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [CNT_BITS-1:0]  count;
    logic [CRED_BITS-1:0] credit_cnt;     // free slots in decode

    // send only with an entry and a credit
    assign fetch_valid_o = (count != '0) && (credit_cnt != '0);
    assign fetch_pc_o    = pc_mem[rd_ptr];
    assign fetch_inst_o  = inst_mem[rd_ptr];

    // reserve a slot for the request still in the cache
    assign full_o = (int'(count) + int'(inflight_i)) >= QUEUE_DEPTH;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRED_BITS'(CREDITS);
        end else begin
            if (enq_i) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fetch_valid_o) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            case ({enq_i, fetch_valid_o})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // a return and a send in the same cycle cancel
            case ({credit_return_i, fetch_valid_o})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (enq_i) begin
            pc_mem[wr_ptr]   <= enq_pc_i;
            inst_mem[wr_ptr] <= enq_inst_i;
        end
    end

endmodule : fetch_queue

//--- logic/fetch_top.sv
module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h1eceb000,
    parameter int               ICACHE_SETS = 4,
    parameter int               QUEUE_DEPTH = 8,
    parameter int               CREDITS     = 4
) (
    input  logic              clk,
    input  logic              rst,

    output fetch_pkg::addr_t  bmem_addr_o,
    output logic              bmem_read_o,
    input  logic              bmem_ready_i,
    input  fetch_pkg::beat_t  bmem_rdata_i,
    input  logic              bmem_rvalid_i,

    output logic              fetch_valid_o,
    output fetch_pkg::addr_t  fetch_pc_o,
    output fetch_pkg::word_t  fetch_inst_o,
    input  logic              credit_return_i
);

    // pc side
    logic             req_valid;
    fetch_pkg::addr_t req_addr;
    logic             inflight;
    logic             queue_full;

    // cache response
    logic             resp_valid;
    fetch_pkg::word_t resp_inst;

    // refill path
    logic             fill_req;
    fetch_pkg::addr_t fill_addr;
    logic             fill_done;
    fetch_pkg::line_t fill_line;

    pc_sequencer #(
        .RESET_PC(RESET_PC)
    ) pc_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .queue_full_i (queue_full),
        .resp_valid_i (resp_valid),
        .req_valid_o  (req_valid),
        .req_addr_o   (req_addr),
        .inflight_o   (inflight)
    );

    icache #(
        .ICACHE_SETS(ICACHE_SETS)
    ) icache_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .resp_valid_o (resp_valid),
        .resp_inst_o  (resp_inst),
        .fill_req_o   (fill_req),
        .fill_addr_o  (fill_addr),
        .fill_done_i  (fill_done),
        .fill_line_i  (fill_line)
    );

    line_fill line_fill_i (
        .clk           (clk),
        .rst           (rst),
        .fill_req_i    (fill_req),
        .fill_addr_i   (fill_addr),
        .fill_done_o   (fill_done),
        .fill_line_o   (fill_line),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // pc of the pending request is still on req_addr when the response lands
    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .CREDITS     (CREDITS)
    ) fetch_queue_i (
        .clk             (clk),
        .rst             (rst),
        .enq_i           (resp_valid),
        .enq_pc_i        (req_addr),
        .enq_inst_i      (resp_inst),
        .inflight_i      (inflight),
        .full_o          (queue_full),
        .fetch_valid_o   (fetch_valid_o),
        .fetch_pc_o      (fetch_pc_o),
        .fetch_inst_o    (fetch_inst_o),
        .credit_return_i (credit_return_i)
    );

endmodule : fetch_top

//--- logic/icache.sv
module icache #(
    parameter int ICACHE_SETS = 4
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             req_valid_i,
    input  fetch_pkg::addr_t req_addr_i,
    output logic             resp_valid_o,
    output fetch_pkg::word_t resp_inst_o,

    output logic             fill_req_o,
    output fetch_pkg::addr_t fill_addr_o,
    input  logic             fill_done_i,
    input  fetch_pkg::line_t fill_line_i
);

    localparam int INDEX_BITS = $clog2(ICACHE_SETS);
    localparam int TAG_BITS   = fetch_pkg::XLEN - INDEX_BITS - fetch_pkg::OFFSET_BITS;
    localparam int WSEL_BITS  = $clog2(fetch_pkg::WORDS_PER_LINE);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT
    } state_t;

    state_t state;

    fetch_pkg::addr_t    req_addr;      // latched request
    fetch_pkg::line_t    line_mem [ICACHE_SETS];
    logic [TAG_BITS-1:0] tag_mem  [ICACHE_SETS];
    logic [ICACHE_SETS-1:0] valid;

    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic [WSEL_BITS-1:0]  word_sel;
    logic                  hit;
    fetch_pkg::line_t      hit_line;

    // address split
    assign tag      = req_addr[fetch_pkg::XLEN-1 -: TAG_BITS];
    assign index    = req_addr[fetch_pkg::OFFSET_BITS +: INDEX_BITS];
    assign word_sel = req_addr[2 +: WSEL_BITS];

    assign hit      = valid[index] && (tag_mem[index] == tag);
    assign hit_line = line_mem[index];

    assign resp_valid_o = (state == LOOKUP) && hit;
    assign resp_inst_o  = hit_line[word_sel * fetch_pkg::XLEN +: fetch_pkg::XLEN];

    // miss request lasts the single lookup cycle
    assign fill_req_o  = (state == LOOKUP) && !hit;
    assign fill_addr_o = {req_addr[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                          {fetch_pkg::OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            valid <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid_i) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= hit ? IDLE : MISS_WAIT;
                end
                MISS_WAIT: begin
                    if (fill_done_i) begin
                        valid[index] <= 1'b1;
                        state        <= LOOKUP;     // replay, hits next cycle
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // tag and line arrays
    always_ff @(posedge clk) begin
        if ((state == IDLE) && req_valid_i) begin
            req_addr <= req_addr_i;
        end
        if ((state == MISS_WAIT) && fill_done_i) begin
            line_mem[index] <= fill_line_i;
            tag_mem[index]  <= tag;
        end
    end

endmodule : icache

//--- logic/line_fill.sv
module line_fill (
    input  logic             clk,
    input  logic             rst,

    input  logic             fill_req_i,
    input  fetch_pkg::addr_t fill_addr_i,
    output logic             fill_done_o,
    output fetch_pkg::line_t fill_line_o,

    output fetch_pkg::addr_t bmem_addr_o,
    output logic             bmem_read_o,
    input  logic             bmem_ready_i,
    input  fetch_pkg::beat_t bmem_rdata_i,
    input  logic             bmem_rvalid_i
);

    localparam int CNT_BITS = $clog2(fetch_pkg::BEATS_PER_LINE);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        BEATS
    } state_t;

    state_t              state;
    logic [CNT_BITS-1:0] beat_cnt;
    logic                last_beat;

    assign last_beat = bmem_rvalid_i &&
                       (beat_cnt == CNT_BITS'(fetch_pkg::BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= IDLE;
            bmem_read_o <= 1'b0;
            beat_cnt    <= '0;
            fill_done_o <= 1'b0;
        end else begin
            fill_done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (fill_req_i) begin
                        bmem_read_o <= 1'b1;
                        state       <= REQUEST;
                    end
                end
                REQUEST: begin
                    // held until memory takes it
                    if (bmem_ready_i) begin
                        bmem_read_o <= 1'b0;
                        beat_cnt    <= '0;
                        state       <= BEATS;
                    end
                end
                BEATS: begin
                    if (bmem_rvalid_i) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (last_beat) begin
                        fill_done_o <= 1'b1;
                        state       <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // beats shift in from the top, first beat ends up at bit 0
    always_ff @(posedge clk) begin
        if ((state == IDLE) && fill_req_i) begin
            bmem_addr_o <= fill_addr_i;
        end
        if ((state == BEATS) && bmem_rvalid_i) begin
            fill_line_o <= {bmem_rdata_i,
                            fill_line_o[fetch_pkg::LINE_BITS-1:fetch_pkg::BEAT_BITS]};
        end
    end

endmodule : line_fill

//--- logic/pc_sequencer.sv
module pc_sequencer #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1eceb000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             queue_full_i,
    input  logic             resp_valid_i,
    output logic             req_valid_o,
    output fetch_pkg::addr_t req_addr_o,
    output logic             inflight_o
);

    fetch_pkg::addr_t pc;
    logic             busy;     // request sent, response pending

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC;
            busy        <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= 1'b0;        // one cycle pulse
            if (resp_valid_i) begin
                pc <= pc + 32'd4;
                // full already counts this response, so the next
                // request can follow right behind it
                if (!queue_full_i) begin
                    req_valid_o <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end else if (!busy && !queue_full_i) begin
                req_valid_o <= 1'b1;
                busy        <= 1'b1;
            end
        end
    end

    // pc only moves on a response
    assign req_addr_o = pc;
    assign inflight_o = busy;

endmodule : pc_sequencer

//--- sim/clk_gen.sv
module clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, after the last reset posedge
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o <= 1'b0;
    end

endmodule : clk_gen

//--- sim/fetch_golden.mem
// first value: number of words to fetch, in hex
// then the words from the reset address upward, four per line
00000020
00500093 00a00113 002081b3 40208233
0041f2b3 0041e333 00209393 0020d413
fff00493 01f4d513 00a02023 00002583
00b50633 00c5f6b3 00d64733 00e687b3
00f70833 0107f8b3 01185933 011899b3
01298a33 41390ab3 014a8b33 015a6bb3
016b7c33 017bccb3 018c8d33 019d0db3
01ad8e33 00000013 00000013 0000006f

//--- sim/fetch_sva.sv
module fetch_sva #(
    parameter int CREDITS = 4
) (
    input logic             clk,
    input logic             rst,
    input logic             bmem_read_i,
    input logic             bmem_ready_i,
    input fetch_pkg::addr_t bmem_addr_i,
    input logic             fetch_valid_i,
    input logic             credit_return_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int sent;   // sent to decode, not yet returned

    always_ff @(posedge clk) begin
        if (rst) begin
            sent <= 0;
        end else begin
            sent <= sent + int'(fetch_valid_i) - int'(credit_return_i);
        end
    end

    credits_not_overspent: assert property (@(posedge clk) disable iff (rst)
        sent <= CREDITS)
        else $error("more instructions outstanding at decode than credits");

    read_held_until_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i && !bmem_ready_i |=> bmem_read_i && $stable(bmem_addr_i))
        else $error("bmem read request dropped or changed before acceptance");

    quiet_in_reset: assert property (@(posedge clk) rst |=> !fetch_valid_i)
        else $error("fetch_valid_o high after a reset cycle");

endmodule : fetch_sva

bind fetch_top fetch_sva #(.CREDITS(CREDITS)) fetch_sva_i (
    .clk             (clk),
    .rst             (rst),
    .bmem_read_i     (bmem_read_o),
    .bmem_ready_i    (bmem_ready_i),
    .bmem_addr_i     (bmem_addr_o),
    .fetch_valid_i   (fetch_valid_o),
    .credit_return_i (credit_return_i)
);

//--- sim/tb_fetch.sv
module tb_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam fetch_pkg::addr_t RESET_PC = 32'h1eceb000;
    localparam int CREDITS      = 4;
    localparam int IMAGE_WORDS  = 32;
    localparam int HOLD_CYCLES  = 40;   // credits withheld this long
    localparam int DRAIN_CYCLES = 40;   // quiet time after the last instruction
    localparam int LINE_BYTES   = fetch_pkg::LINE_BITS / 8;

    typedef enum logic [1:0] {MEM_IDLE, MEM_DELAY, MEM_BEATS} mem_state_t;

    logic             clk;
    logic             rst;
    fetch_pkg::addr_t bmem_addr;
    logic             bmem_read;
    logic             bmem_ready = 1'b0;
    fetch_pkg::beat_t bmem_rdata = '0;
    logic             bmem_rvalid = 1'b0;
    logic             fetch_valid;
    fetch_pkg::addr_t fetch_pc;
    fetch_pkg::word_t fetch_inst;
    logic             credit_return = 1'b0;

    fetch_pkg::word_t golden_mem [0:IMAGE_WORDS];   // entry 0 holds the count
    int               golden_count = 0;
    fetch_pkg::addr_t exp_pc = RESET_PC;
    int               received = 0;
    int               outstanding = 0;    // credits held by decode
    int               accepted_reads = 0;
    bit               returns_on = 1'b0;
    mem_state_t       mem_state = MEM_IDLE;
    int               delay_left = 0;
    int               beat_idx = 0;
    int               burst_word = 0;     // image index of the burst's first word

    clk_gen #(.PERIOD(10), .RESET_CYCLES(5)) clk_gen_i (.clk_o(clk), .rst_o(rst));

    fetch_top #(
        .RESET_PC    (RESET_PC),
        .ICACHE_SETS (4),
        .QUEUE_DEPTH (8),
        .CREDITS     (CREDITS)
    ) fetch_top_i (
        .clk             (clk),
        .rst             (rst),
        .bmem_addr_o     (bmem_addr),
        .bmem_read_o     (bmem_read),
        .bmem_ready_i    (bmem_ready),
        .bmem_rdata_i    (bmem_rdata),
        .bmem_rvalid_i   (bmem_rvalid),
        .fetch_valid_o   (fetch_valid),
        .fetch_pc_o      (fetch_pc),
        .fetch_inst_o    (fetch_inst),
        .credit_return_i (credit_return)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input fetch_pkg::word_t got,
                              input fetch_pkg::word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    function automatic bit in_image(input fetch_pkg::addr_t addr);
        return (addr >= RESET_PC) &&
               ((addr - RESET_PC) < fetch_pkg::addr_t'(golden_count * 4));
    endfunction

    // decode side takes an instruction and hands credits back at random
    task automatic serve_decode();
        int idx;
        if (fetch_valid === 1'b1) begin
            idx = int'((exp_pc - RESET_PC) >> 2);
            if (idx >= golden_count) begin
                stop_with_failure("more instructions delivered than the golden count");
            end
            check_addr("fetch_pc_o", fetch_pc, exp_pc);
            check_word("fetch_inst_o", fetch_inst, golden_mem[1 + idx]);
            exp_pc = exp_pc + 32'd4;
            received++;
            outstanding++;
            if (!returns_on && received > CREDITS) begin
                stop_with_failure("fetch_valid_o pulsed with no credit left");
            end
        end else if (fetch_valid !== 1'b0) begin
            stop_with_failure("fetch_valid_o is unknown");
        end
        credit_return = 1'b0;
        if (returns_on && outstanding > 0 && $urandom_range(0, 2) == 0) begin
            credit_return = 1'b1;
            outstanding--;
        end
    endtask

    // burst memory that serves only lines inside the image
    task automatic serve_memory();
        bmem_ready  = 1'b0;
        bmem_rvalid = 1'b0;
        if (mem_state == MEM_IDLE) begin
            if (bmem_read === 1'b1) begin
                // lines miss in pc order, one burst each
                check_addr("bmem_addr_o", bmem_addr,
                           RESET_PC + fetch_pkg::addr_t'(accepted_reads * LINE_BYTES));
            end
            if (bmem_read === 1'b1 && in_image(bmem_addr) && $urandom_range(0, 1) == 1) begin
                bmem_ready = 1'b1;    // taken at the next posedge
                burst_word = int'((bmem_addr - RESET_PC) >> 2);
                delay_left = int'($urandom_range(0, 3));
                beat_idx   = 0;
                accepted_reads++;
                mem_state  = MEM_DELAY;
            end
        end else begin
            if (mem_state == MEM_DELAY) begin
                if (delay_left == 0) begin
                    mem_state = MEM_BEATS;
                end else begin
                    delay_left--;
                end
            end
            if (mem_state == MEM_BEATS) begin
                bmem_rvalid = 1'b1;
                bmem_rdata  = {golden_mem[2 + burst_word + 2 * beat_idx],
                               golden_mem[1 + burst_word + 2 * beat_idx]};
                beat_idx++;
                if (beat_idx == fetch_pkg::BEATS_PER_LINE) begin
                    mem_state = MEM_IDLE;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst === 1'b0) begin
            serve_decode();
            serve_memory();
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hd3c974d7));
        $readmemh("sim/fetch_golden.mem", golden_mem);
        golden_count = int'(golden_mem[0]);
        if (golden_count < 1 || golden_count > IMAGE_WORDS) begin
            stop_with_failure("golden file holds a bad instruction count");
        end

        @(posedge clk);   // registers now hold their reset values
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            if (rst === 1'b1 && (fetch_valid !== 1'b0 || bmem_read !== 1'b0)) begin
                stop_with_failure("fetch_valid_o or bmem_read_o not low during reset");
            end
            if (cycles > 20) begin
                stop_with_failure("reset was never released");
            end
        end

        // decode sees at most CREDITS instructions until returns start
        cycles = 0;
        while (received < CREDITS) begin
            @(posedge clk);
            cycles++;
            if (cycles > 2000) begin
                stop_with_failure("timed out waiting for the first instructions");
            end
        end
        repeat (HOLD_CYCLES) @(posedge clk);
        returns_on = 1'b1;

        cycles = 0;
        while (received < golden_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10000) begin
                stop_with_failure("timed out waiting for the golden count of instructions");
            end
        end

        // anything fetched past the image would reach decode here
        repeat (DRAIN_CYCLES) @(posedge clk);

        // hits need no memory traffic so each line costs one burst
        check_count("accepted bmem reads", accepted_reads,
                    (golden_count + fetch_pkg::WORDS_PER_LINE - 1) / fetch_pkg::WORDS_PER_LINE);
        $display("Test completed successfully");
        $finish;
    end

endmodule : tb_fetch

//--- src.f
logic/fetch_pkg.sv
logic/pc_sequencer.sv
logic/icache.sv
logic/line_fill.sv
logic/fetch_queue.sv
logic/fetch_top.sv
sim/clk_gen.sv
sim/fetch_sva.sv
sim/tb_fetch.sv
